// File: sb_isa_pkg.sv
// Scoreboard ISA definitions
// Architectural register indexing and the issue classes that the
// scoreboard can see at the issue point of the execute stage.

package sb_isa_pkg;

    // ====================================================================
    // Register file
    // ====================================================================

    // Architectural register index, x0 to x31
    typedef logic [4:0] reg_addr_t;

    // Source operands compared against in-flight destinations
    localparam int unsigned NUM_SRC = 2;

    // Hard-wired zero, never a hazard
    localparam reg_addr_t ZERO_REG = 5'd0;

    // ====================================================================
    // Issue classes
    // ====================================================================

    // Bit positions in the unit select vector
    localparam int unsigned UNIT_ALU  = 0;
    localparam int unsigned UNIT_CSR  = 1;
    localparam int unsigned UNIT_MUL  = 2;
    localparam int unsigned UNIT_DIV  = 3;
    localparam int unsigned NUM_UNITS = 4;

endpackage : sb_isa_pkg

// File: sb_timing_pkg.sv
// Scoreboard timing definitions
// Execute unit latencies as seen from the issue point, the bypass stage
// in front of the units, and the width of the result countdown counters.

package sb_timing_pkg;

    // ====================================================================
    // Unit latencies
    // ====================================================================

    // Pipelined multiplier, one result slot per stage
    localparam int unsigned MUL_LATENCY = 5;

    // Iterative divider, single slot
    localparam int unsigned DIV_LATENCY = 35;

    // ALU and CSR results land in one cycle
    localparam int unsigned SINGLE_LATENCY = 1;

    // Bypass stage between issue and the execute units
    localparam int unsigned BYPASS_CYCLES = 1;

    // ====================================================================
    // Counter widths
    // ====================================================================

    // Must hold the longest requested latency, divider plus bypass
    localparam int unsigned LAT_W = $clog2(DIV_LATENCY + BYPASS_CYCLES + 1);

    // Latency request and slot countdown value
    typedef logic [LAT_W-1:0] lat_t;

endpackage : sb_timing_pkg

// File: result_slot.sv
// Result slot
// Tracks one in-flight result of a long-latency execute unit. A countdown
// is loaded when the unit accepts an instruction and the destination is
// kept for compares against the instruction waiting at issue.
// Reports busy, RAW/WAW hazards and write-back collisions.

module result_slot #(
    parameter sb_timing_pkg::lat_t LOAD_CYCLES = 1
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  stall_i,
    // Accept into this slot
    input  logic                  load_i,
    input  sb_isa_pkg::reg_addr_t dest_i,
    // Instruction waiting at issue
    input  sb_isa_pkg::reg_addr_t src0_i,
    input  sb_isa_pkg::reg_addr_t src1_i,
    input  sb_isa_pkg::reg_addr_t new_dest_i,
    input  sb_timing_pkg::lat_t   req_latency_i,
    // Slot status
    output logic                  busy_o,
    output logic                  raw_hazard_o,
    output logic                  latency_hazard_o
);

    import sb_isa_pkg::*;
    import sb_timing_pkg::*;

    lat_t                    cnt_q;
    reg_addr_t               dest_q;
    reg_addr_t [NUM_SRC-1:0] src_regs;
    logic      [NUM_SRC-1:0] src_match;
    logic                    dest_match;

    // ====================================================================
    // Countdown and destination
    // ====================================================================

    // Flush drops the result, stall freezes it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (flush_i) begin
            cnt_q <= '0;
        end else if (!stall_i) begin
            if (load_i) begin
                cnt_q <= LOAD_CYCLES;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - lat_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            dest_q <= ZERO_REG;
        end else if (!stall_i && load_i) begin
            dest_q <= dest_i;
        end
    end

    // ====================================================================
    // Hazard compares
    // ====================================================================

    // Last cycle of the countdown is covered by the bypass
    assign busy_o = (cnt_q > lat_t'(1));

    assign src_regs = {src1_i, src0_i};

    for (genvar s = 0; s < NUM_SRC; s++) begin : gen_src_cmp
        assign src_match[s] = (src_regs[s] == dest_q);
    end

    // WAW on the new destination
    assign dest_match = (new_dest_i == dest_q);

    // x0 writes are discarded, so never a dependency
    assign raw_hazard_o = busy_o && (dest_q != ZERO_REG) && ((|src_match) || dest_match);

    // New result would hit write-back in the same cycle as this one
    assign latency_hazard_o = busy_o && (cnt_q == req_latency_i);

    a_cnt_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cnt_q <= LOAD_CYCLES)
        else $error("result slot countdown above its load value");

endmodule : result_slot

// File: mul_tracker.sv
// Multiplier result tracker
// One result slot per multiplier stage, so that a new multiply may be
// accepted every cycle. A rotating one-hot pointer picks the slot that
// takes the next accepted multiply. Slot flags are merged for issue.

module mul_tracker (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  stall_i,
    // Multiply granted at issue and not yet qualified by stall
    input  logic                  mul_issue_i,
    // Instruction waiting at issue
    input  sb_isa_pkg::reg_addr_t dest_i,
    input  sb_isa_pkg::reg_addr_t src0_i,
    input  sb_isa_pkg::reg_addr_t src1_i,
    input  sb_timing_pkg::lat_t   req_latency_i,
    // Merged status of all stages
    output logic                  busy_o,
    output logic                  raw_hazard_o,
    output logic                  latency_hazard_o
);

    import sb_timing_pkg::*;

    logic [MUL_LATENCY-1:0] ptr_q;
    logic [MUL_LATENCY-1:0] slot_load;
    logic [MUL_LATENCY-1:0] slot_busy;
    logic [MUL_LATENCY-1:0] slot_raw;
    logic [MUL_LATENCY-1:0] slot_lat;

    // ====================================================================
    // Stage pointer
    // ====================================================================

    // Rotates left on every accepted multiply and wraps back to stage 0
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptr_q <= MUL_LATENCY'(1);
        end else if (flush_i) begin
            ptr_q <= MUL_LATENCY'(1);
        end else if (!stall_i && mul_issue_i) begin
            ptr_q <= {ptr_q[MUL_LATENCY-2:0], ptr_q[MUL_LATENCY-1]};
        end
    end

    // ====================================================================
    // Stage slots
    // ====================================================================

    for (genvar i = 0; i < MUL_LATENCY; i++) begin : gen_slot
        // Only the pointed stage captures the multiply
        assign slot_load[i] = mul_issue_i && ptr_q[i];

        result_slot #(
            .LOAD_CYCLES (lat_t'(MUL_LATENCY))
        ) slot_i (
            .clk_i            (clk_i),
            .rst_n_i          (rst_n_i),
            .flush_i          (flush_i),
            .stall_i          (stall_i),
            .load_i           (slot_load[i]),
            .dest_i           (dest_i),
            .src0_i           (src0_i),
            .src1_i           (src1_i),
            .new_dest_i       (dest_i),
            .req_latency_i    (req_latency_i),
            .busy_o           (slot_busy[i]),
            .raw_hazard_o     (slot_raw[i]),
            .latency_hazard_o (slot_lat[i])
        );
    end

    // Any stage in flight blocks
    assign busy_o           = |slot_busy;
    assign raw_hazard_o     = |slot_raw;
    assign latency_hazard_o = |slot_lat;

    // ====================================================================
    // Checks
    // ====================================================================

    a_ptr_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot(ptr_q))
        else $error("multiplier stage pointer lost its one-hot state");

endmodule : mul_tracker

// File: issue_control.sv
// Issue control
// Decodes the write-back latency of the instruction at issue, merges
// the RAW, write-back collision and divider structural hazards into a
// single combinational grant, and flags an empty execute stage.

module issue_control (
    // Unit select of the instruction at issue
    input  logic                alu_i,
    input  logic                csr_i,
    input  logic                mul_i,
    input  logic                div_i,
    // Multiplier tracker status
    input  logic                mul_raw_i,
    input  logic                mul_lat_i,
    input  logic                mul_busy_i,
    // Divider slot status
    input  logic                div_raw_i,
    input  logic                div_lat_i,
    input  logic                div_busy_i,
    // To the slots
    output sb_timing_pkg::lat_t req_latency_o,
    output logic                mul_issue_o,
    output logic                div_issue_o,
    // Issue decision
    output logic                issue_o,
    output logic                pipeline_empty_o
);

    import sb_isa_pkg::*;
    import sb_timing_pkg::*;

    logic [NUM_UNITS-1:0] unit_sel;
    logic                 raw_hazard;
    logic                 latency_hazard;
    logic                 struct_hazard;

    assign unit_sel[UNIT_ALU] = alu_i;
    assign unit_sel[UNIT_CSR] = csr_i;
    assign unit_sel[UNIT_MUL] = mul_i;
    assign unit_sel[UNIT_DIV] = div_i;

    // ====================================================================
    // Latency decode
    // ====================================================================

    // Requested latency includes the bypass stage
    always_comb begin
        if (unit_sel[UNIT_MUL]) begin
            req_latency_o = lat_t'(MUL_LATENCY + BYPASS_CYCLES);
        end else if (unit_sel[UNIT_DIV]) begin
            req_latency_o = lat_t'(DIV_LATENCY + BYPASS_CYCLES);
        end else if (unit_sel[UNIT_ALU] || unit_sel[UNIT_CSR]) begin
            req_latency_o = lat_t'(SINGLE_LATENCY + BYPASS_CYCLES);
        end else begin
            // No unit, value no slot counter can reach
            req_latency_o = '1;
        end
    end

    // ====================================================================
    // Hazard merge and grant
    // ====================================================================

    assign raw_hazard     = mul_raw_i || div_raw_i;
    assign latency_hazard = mul_lat_i || div_lat_i;

    // Divider is not pipelined
    assign struct_hazard  = unit_sel[UNIT_DIV] && div_busy_i;

    assign issue_o = !(raw_hazard || latency_hazard || struct_hazard);

    // Slots apply stall themselves
    assign mul_issue_o = unit_sel[UNIT_MUL] && issue_o;
    assign div_issue_o = unit_sel[UNIT_DIV] && issue_o;

    // Nothing left in flight in the long-latency units
    assign pipeline_empty_o = !(mul_busy_i || div_busy_i);

    a_unit_onehot0: assert final ($onehot0(unit_sel))
        else $error("more than one execute unit selected at issue");

endmodule : issue_control

// File: issue_scoreboard.sv
// Execute stage issue scoreboard
// Holds back the instruction at issue on RAW/WAW hazards against
// in-flight multiplier and divider results, on write-back collisions
// and on a busy divider. Also reports an empty execute stage.

module issue_scoreboard (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // Unit select, at most one high
    input  logic                  alu_i,
    input  logic                  csr_i,
    input  logic                  mul_i,
    input  logic                  div_i,
    // Operands of the instruction at issue
    input  sb_isa_pkg::reg_addr_t src0_i,
    input  sb_isa_pkg::reg_addr_t src1_i,
    input  sb_isa_pkg::reg_addr_t dest_i,
    // Pipeline control
    input  logic                  stall_i,
    input  logic                  flush_i,
    // Grant and status
    output logic                  issue_o,
    output logic                  pipeline_empty_o
);

    import sb_timing_pkg::*;

    lat_t req_latency;
    logic mul_issue;
    logic div_issue;
    logic mul_busy;
    logic mul_raw;
    logic mul_lat;
    logic div_busy;
    logic div_raw;
    logic div_lat;

    // ====================================================================
    // Result trackers
    // ====================================================================

    mul_tracker mul_tracker_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .stall_i          (stall_i),
        .mul_issue_i      (mul_issue),
        .dest_i           (dest_i),
        .src0_i           (src0_i),
        .src1_i           (src1_i),
        .req_latency_i    (req_latency),
        .busy_o           (mul_busy),
        .raw_hazard_o     (mul_raw),
        .latency_hazard_o (mul_lat)
    );

    // Single slot, divider takes one operation at a time
    result_slot #(
        .LOAD_CYCLES (lat_t'(DIV_LATENCY))
    ) div_slot_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .stall_i          (stall_i),
        .load_i           (div_issue),
        .dest_i           (dest_i),
        .src0_i           (src0_i),
        .src1_i           (src1_i),
        .new_dest_i       (dest_i),
        .req_latency_i    (req_latency),
        .busy_o           (div_busy),
        .raw_hazard_o     (div_raw),
        .latency_hazard_o (div_lat)
    );

    // ====================================================================
    // Issue decision
    // ====================================================================

    issue_control issue_control_i (
        .alu_i            (alu_i),
        .csr_i            (csr_i),
        .mul_i            (mul_i),
        .div_i            (div_i),
        .mul_raw_i        (mul_raw),
        .mul_lat_i        (mul_lat),
        .mul_busy_i       (mul_busy),
        .div_raw_i        (div_raw),
        .div_lat_i        (div_lat),
        .div_busy_i       (div_busy),
        .req_latency_o    (req_latency),
        .mul_issue_o      (mul_issue),
        .div_issue_o      (div_issue),
        .issue_o          (issue_o),
        .pipeline_empty_o (pipeline_empty_o)
    );

endmodule : issue_scoreboard

// File: tb_issue_scoreboard.sv
// Issue scoreboard testbench
// Drives directed and LFSR-based issue traffic into the scoreboard and
// compares the grant and empty flag with a cycle-level slot model.
// Concurrent assertions compare the DUT with the model.

module tb_issue_scoreboard;

    import sb_isa_pkg::*;
    import sb_timing_pkg::*;

    localparam logic [16:0] LFSR_SEED  = 17'd72863;
    localparam int N_RANDOM            = 400;
    localparam int DIRECTED_CYCLES     = 400;
    localparam int TIMEOUT_CYCLES      = N_RANDOM + DIRECTED_CYCLES + 200;

    // Unit select encodings in the bit order of the ISA package
    localparam logic [3:0] SEL_NONE = 4'b0000;
    localparam logic [3:0] SEL_ALU  = 4'(1 << UNIT_ALU);
    localparam logic [3:0] SEL_CSR  = 4'(1 << UNIT_CSR);
    localparam logic [3:0] SEL_MUL  = 4'(1 << UNIT_MUL);
    localparam logic [3:0] SEL_DIV  = 4'(1 << UNIT_DIV);

    logic      clk_i;
    logic      rst_n_i;
    logic      alu_i;
    logic      csr_i;
    logic      mul_i;
    logic      div_i;
    reg_addr_t src0_i;
    reg_addr_t src1_i;
    reg_addr_t dest_i;
    logic      stall_i;
    logic      flush_i;
    logic      issue_o;
    logic      pipeline_empty_o;

    // Reference slot state
    int        m_cnt [MUL_LATENCY];
    reg_addr_t m_dest [MUL_LATENCY];
    int        m_ptr;
    int        d_cnt;
    reg_addr_t d_dest;
    int        req_lat;
    logic      hazard;
    logic      any_busy;
    logic      exp_issue;
    logic      exp_empty;

    logic [18:0] issue_req;
    logic [16:0] lfsr_q;
    int          cycle_cnt;
    int          issue_errs;
    int          empty_errs;
    int          flush_errs;
    int          stall_errs;

    issue_scoreboard issue_scoreboard_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .alu_i            (alu_i),
        .csr_i            (csr_i),
        .mul_i            (mul_i),
        .div_i            (div_i),
        .src0_i           (src0_i),
        .src1_i           (src1_i),
        .dest_i           (dest_i),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .issue_o          (issue_o),
        .pipeline_empty_o (pipeline_empty_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ====================================================================
    // Reference model
    // ====================================================================

    // Grant and empty flag from the model slots and the request at issue
    always_comb begin
        if (alu_i || csr_i) begin
            req_lat = SINGLE_LATENCY + BYPASS_CYCLES;
        end else if (mul_i) begin
            req_lat = MUL_LATENCY + BYPASS_CYCLES;
        end else if (div_i) begin
            req_lat = DIV_LATENCY + BYPASS_CYCLES;
        end else begin
            req_lat = -1;
        end
        hazard   = 1'b0;
        any_busy = 1'b0;
        for (int i = 0; i < MUL_LATENCY; i++) begin
            if (m_cnt[i] > 1) begin
                any_busy = 1'b1;
                if (m_dest[i] != ZERO_REG &&
                    (m_dest[i] == src0_i || m_dest[i] == src1_i || m_dest[i] == dest_i)) begin
                    hazard = 1'b1;
                end
                if (m_cnt[i] == req_lat) begin
                    hazard = 1'b1;
                end
            end
        end
        if (d_cnt > 1) begin
            any_busy = 1'b1;
            if (d_dest != ZERO_REG &&
                (d_dest == src0_i || d_dest == src1_i || d_dest == dest_i)) begin
                hazard = 1'b1;
            end
            // Write-back collision or a second divide while busy
            if (d_cnt == req_lat || div_i) begin
                hazard = 1'b1;
            end
        end
        exp_issue = !hazard;
        exp_empty = !any_busy;
    end

    // Accept, countdown, flush and stall rules
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < MUL_LATENCY; i++) begin
                m_cnt[i]  <= 0;
                m_dest[i] <= ZERO_REG;
            end
            m_ptr  <= 0;
            d_cnt  <= 0;
            d_dest <= ZERO_REG;
        end else if (flush_i) begin
            for (int i = 0; i < MUL_LATENCY; i++) begin
                m_cnt[i] <= 0;
            end
            m_ptr <= 0;
            d_cnt <= 0;
        end else if (!stall_i) begin
            for (int i = 0; i < MUL_LATENCY; i++) begin
                if (mul_i && exp_issue && i == m_ptr) begin
                    m_cnt[i]  <= MUL_LATENCY;
                    m_dest[i] <= dest_i;
                end else if (m_cnt[i] > 0) begin
                    m_cnt[i] <= m_cnt[i] - 1;
                end
            end
            if (mul_i && exp_issue) begin
                m_ptr <= (m_ptr + 1) % MUL_LATENCY;
            end
            if (div_i && exp_issue) begin
                d_cnt  <= DIV_LATENCY;
                d_dest <= dest_i;
            end else if (d_cnt > 0) begin
                d_cnt <= d_cnt - 1;
            end
        end
    end

    // ====================================================================
    // Checks
    // ====================================================================

    assign issue_req = {alu_i, csr_i, mul_i, div_i, src0_i, src1_i, dest_i};

    a_issue_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_o == exp_issue)
        else begin
            issue_errs++;
            $display("[ERROR] %0t: issue_o is %0b, model expects %0b",
                     $time, $sampled(issue_o), $sampled(exp_issue));
        end

    a_empty_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pipeline_empty_o == exp_empty)
        else begin
            empty_errs++;
            $display("[ERROR] %0t: pipeline_empty_o is %0b, model expects %0b",
                     $time, $sampled(pipeline_empty_o), $sampled(exp_empty));
        end

    // Flushed stage is empty and blocks nothing
    a_flush_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> (pipeline_empty_o && issue_o))
        else begin
            flush_errs++;
            $display("[ERROR] %0t: hazards remain in the cycle after a flush", $time);
        end

    // Frozen slots with an unchanged request give an unchanged grant
    a_stall_freeze: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stall_i && !flush_i) ##1 $stable(issue_req) |-> $stable(issue_o))
        else begin
            stall_errs++;
            $display("[ERROR] %0t: issue_o changed while the stage was stalled", $time);
        end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // ====================================================================
    // Stimulus helpers
    // ====================================================================

    // Fibonacci LFSR with taps for x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic drive(input logic [3:0] sel, input reg_addr_t s0, input reg_addr_t s1,
                         input reg_addr_t d, input logic st, input logic fl);
        @(posedge clk_i);
        alu_i   <= sel[UNIT_ALU];
        csr_i   <= sel[UNIT_CSR];
        mul_i   <= sel[UNIT_MUL];
        div_i   <= sel[UNIT_DIV];
        src0_i  <= s0;
        src1_i  <= s1;
        dest_i  <= d;
        stall_i <= st;
        flush_i <= fl;
    endtask

    task automatic idle(input int n);
        repeat (n) drive(SEL_NONE, '0, '0, '0, 1'b0, 1'b0);
    endtask

    // Holds the request until granted and the next edge accepts it
    task automatic issue_until_granted(input logic [3:0] sel, input reg_addr_t s0,
                                       input reg_addr_t s1, input reg_addr_t d);
        drive(sel, s0, s1, d, 1'b0, 1'b0);
        @(negedge clk_i);
        while (!issue_o) @(negedge clk_i);
    endtask

    task automatic wait_drained();
        idle(1);
        @(negedge clk_i);
        while (!pipeline_empty_o) @(negedge clk_i);
    endtask

    task automatic random_traffic(input int n);
        logic [31:0] u;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] rd;
        logic [31:0] st;
        logic [31:0] fl;
        logic [3:0]  sel;
        for (int k = 0; k < n; k++) begin
            take_bits(3, u);
            take_bits(5, r0);
            take_bits(5, r1);
            take_bits(5, rd);
            take_bits(3, st);
            take_bits(5, fl);
            case (u)
                0, 1:    sel = SEL_ALU;
                2:       sel = SEL_CSR;
                3, 4:    sel = SEL_MUL;
                5:       sel = SEL_DIV;
                default: sel = SEL_NONE;
            endcase
            drive(sel, r0[4:0], r1[4:0], rd[4:0], st == 0, fl == 0);
        end
    endtask

    // ====================================================================
    // Test sequence
    // ====================================================================

    initial begin
        rst_n_i = 1'b0;
        {alu_i, csr_i, mul_i, div_i, stall_i, flush_i} = '0;
        src0_i = '0;
        src1_i = '0;
        dest_i = '0;
        lfsr_q = LFSR_SEED;
        cycle_cnt  = 0;
        issue_errs = 0;
        empty_errs = 0;
        flush_errs = 0;
        stall_errs = 0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Empty after reset so an ALU op goes straight through
        issue_until_granted(SEL_ALU, 5'd3, 5'd4, 5'd5);
        issue_until_granted(SEL_ALU, 5'd0, 5'd31, 5'd1);

        // RAW on a multiply result then WAW, and x0 never blocks
        issue_until_granted(SEL_MUL, 5'd1, 5'd2, 5'd20);
        issue_until_granted(SEL_ALU, 5'd20, 5'd2, 5'd21);
        issue_until_granted(SEL_MUL, 5'd1, 5'd2, 5'd22);
        issue_until_granted(SEL_ALU, 5'd3, 5'd4, 5'd22);
        issue_until_granted(SEL_MUL, 5'd1, 5'd2, 5'd0);
        issue_until_granted(SEL_ALU, 5'd0, 5'd0, 5'd0);
        wait_drained();

        // Write-back collision at every offset behind a multiply
        for (int dly = 0; dly < MUL_LATENCY; dly++) begin
            issue_until_granted(SEL_MUL, 5'd1, 5'd2, 5'd5);
            idle(dly);
            issue_until_granted(SEL_ALU, 5'd6, 5'd7, 5'd8);
            wait_drained();
            issue_until_granted(SEL_MUL, 5'd1, 5'd2, 5'd5);
            idle(dly);
            issue_until_granted(SEL_CSR, 5'd6, 5'd7, 5'd8);
            wait_drained();
        end

        // Second divide waits out the busy divider
        issue_until_granted(SEL_DIV, 5'd1, 5'd2, 5'd9);
        issue_until_granted(SEL_DIV, 5'd11, 5'd11, 5'd10);
        wait_drained();

        // Back-to-back multiplies through all stages
        for (int i = 0; i < MUL_LATENCY; i++) begin
            issue_until_granted(SEL_MUL, 5'd1, 5'd2, reg_addr_t'(24 + i));
        end
        wait_drained();

        // Stall holds a blocked request and its slot
        issue_until_granted(SEL_MUL, 5'd1, 5'd2, 5'd12);
        repeat (4) drive(SEL_ALU, 5'd12, 5'd3, 5'd4, 1'b1, 1'b0);
        issue_until_granted(SEL_ALU, 5'd12, 5'd3, 5'd4);
        wait_drained();

        // Flush drops everything in flight
        issue_until_granted(SEL_DIV, 5'd1, 5'd2, 5'd13);
        issue_until_granted(SEL_MUL, 5'd1, 5'd2, 5'd14);
        issue_until_granted(SEL_MUL, 5'd1, 5'd2, 5'd15);
        drive(SEL_ALU, 5'd13, 5'd14, 5'd15, 1'b0, 1'b1);
        issue_until_granted(SEL_ALU, 5'd13, 5'd14, 5'd15);
        wait_drained();

        random_traffic(N_RANDOM);
        idle(2);

        $display("Error counts: issue %0d, empty %0d, flush %0d, stall %0d",
                 issue_errs, empty_errs, flush_errs, stall_errs);
        if (issue_errs + empty_errs + flush_errs + stall_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_issue_scoreboard

// File: src.f
sb_isa_pkg.sv
sb_timing_pkg.sv
result_slot.sv
mul_tracker.sv
issue_control.sv
issue_scoreboard.sv
tb_issue_scoreboard.sv

// File: Bender.yml
package:
  name: issue_scoreboard

sources:
  - sb_isa_pkg.sv
  - sb_timing_pkg.sv
  - result_slot.sv
  - mul_tracker.sv
  - issue_control.sv
  - issue_scoreboard.sv
  - target: simulation
    files:
      - tb_issue_scoreboard.sv
